// File: ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

////////////////////////////////////////
// Execute stage sizing
////////////////////////////////////////

// Datapath word width
`define EX_XLEN 32

// Register file address width
// Six bits leave room for registers past the 32 integer ones
`define EX_RADDR_W 6

// One lane of a halfword vector operation
// Two lanes must fill exactly one word
`define EX_HALF_W 16

`endif

// File: ex_op_pkg.sv
package ex_op_pkg;

  ////////////////////////////////////////
  // ALU operators
  ////////////////////////////////////////

  // Arithmetic, logic and shifts first, then set-less-than, then branch compares
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  ////////////////////////////////////////
  // Multiplier operators
  ////////////////////////////////////////

  // Low product, low product plus c, high product
  typedef enum logic [1:0] {
    MULT_MUL  = 2'd0,
    MULT_MAC  = 2'd1,
    MULT_MULH = 2'd2
  } mult_op_e;

  // Signedness of operand a and operand b for the high product
  typedef enum logic [1:0] {
    MULT_UU = 2'd0,
    MULT_SU = 2'd1,
    MULT_SS = 2'd2
  } mult_sign_e;

  // ALU vector mode
  typedef enum logic {
    VEC_WORD = 1'b0,
    VEC_HALF = 1'b1
  } vec_mode_e;

endpackage

// File: ex_data_pkg.sv
`include "ex_cfg.svh"

package ex_data_pkg;

  // Two halfword lanes, high lane in the upper bits
  typedef struct packed {
    logic [`EX_HALF_W-1:0] hi;
    logic [`EX_HALF_W-1:0] lo;
  } half_pair_t;

  // One operand word
  // Word mode reads it whole, half mode reads the two lanes
  typedef union packed {
    logic [`EX_XLEN-1:0] word;
    half_pair_t          half;
  } ex_word_u;

  // Register file address
  typedef logic [`EX_RADDR_W-1:0] reg_addr_t;

endpackage

// File: ex_res_if.sv
`timescale 1ns/10ps
`include "ex_cfg.svh"

interface ex_res_if;

  // ALU result and comparison bit
  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp;

  // Multiplier result and status
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;
  logic                mult_multicycle;

  // Stage ready, fed back to the multiplier
  logic                ex_ready;

  modport alu_mp (
    output alu_result,
    output alu_cmp
  );

  modport mult_mp (
    input  ex_ready,
    output mult_result,
    output mult_ready,
    output mult_multicycle
  );

  modport ctrl_mp (
    input  alu_result,
    input  mult_result,
    input  mult_ready,
    output ex_ready
  );

endinterface

// File: ex_alu.sv
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_alu import ex_op_pkg::*, ex_data_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      enable_i,
  input  alu_op_e   operator_i,
  input  vec_mode_e vec_mode_i,
  input  ex_word_u  operand_a_i,
  input  ex_word_u  operand_b_i,
  ex_res_if.alu_mp  res
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic                is_sub;
  ex_word_u            addsub;
  logic [SHAMT_W-1:0]  shamt;
  logic                lt_s;
  logic                lt_u;
  logic                eq;
  logic                cmp;
  logic [`EX_XLEN-1:0] result;

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  assign is_sub = (operator_i == ALU_SUB);

  // Half mode keeps the lanes apart, no carry or borrow crosses lane 0
  always_comb begin
    if (vec_mode_i == VEC_HALF) begin
      if (is_sub) begin
        addsub.half.hi = operand_a_i.half.hi - operand_b_i.half.hi;
        addsub.half.lo = operand_a_i.half.lo - operand_b_i.half.lo;
      end else begin
        addsub.half.hi = operand_a_i.half.hi + operand_b_i.half.hi;
        addsub.half.lo = operand_a_i.half.lo + operand_b_i.half.lo;
      end
    end else begin
      addsub.word = is_sub ? operand_a_i.word - operand_b_i.word
                           : operand_a_i.word + operand_b_i.word;
    end
  end

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  assign lt_s = $signed(operand_a_i.word) < $signed(operand_b_i.word);
  assign lt_u = operand_a_i.word < operand_b_i.word;
  assign eq   = (operand_a_i.word == operand_b_i.word);

  // Set-less-than and branch compares share the same flags
  always_comb begin
    case (operator_i)
      ALU_SLT, ALU_LT:   cmp = lt_s;
      ALU_SLTU, ALU_LTU: cmp = lt_u;
      ALU_EQ:            cmp = eq;
      ALU_NE:            cmp = ~eq;
      ALU_GE:            cmp = ~lt_s;
      ALU_GEU:           cmp = ~lt_u;
      default:           cmp = 1'b0;
    endcase
  end

  // Shift amount from the low bits of b
  assign shamt = operand_b_i.word[SHAMT_W-1:0];

  // Result select, compares give the zero-extended flag
  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB: result = addsub.word;
      ALU_AND:          result = operand_a_i.word & operand_b_i.word;
      ALU_OR:           result = operand_a_i.word | operand_b_i.word;
      ALU_XOR:          result = operand_a_i.word ^ operand_b_i.word;
      ALU_SLL:          result = operand_a_i.word << shamt;
      ALU_SRL:          result = operand_a_i.word >> shamt;
      ALU_SRA:          result = $unsigned($signed(operand_a_i.word) >>> shamt);
      default:          result = {{(`EX_XLEN-1){1'b0}}, cmp};
    endcase
  end

  assign res.alu_result = result;
  assign res.alu_cmp    = cmp;

  // Decoder upstream must present a clean operator whenever the ALU is used
  a_op_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    enable_i |-> !$isunknown(operator_i)
  ) else $error("ALU enabled with unknown operator");

endmodule

// File: ex_mult.sv
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_mult import ex_op_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable_i,
  input  mult_op_e            operator_i,
  input  mult_sign_e          signed_mode_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  input  logic [`EX_XLEN-1:0] op_c_i,
  ex_res_if.mult_mp           res
);

  typedef enum logic {
    MULT_IDLE   = 1'b0,
    MULT_FINISH = 1'b1
  } mult_state_e;

  mult_state_e                state_q;
  mult_state_e                state_d;
  logic                       sign_a;
  logic                       sign_b;
  logic                       start_high;
  logic signed [`EX_XLEN:0]   a_ext;
  logic signed [`EX_XLEN:0]   b_ext;
  logic signed [2*`EX_XLEN+1:0] prod_full;
  logic [2*`EX_XLEN-1:0]      prod_q;
  logic [`EX_XLEN-1:0]        prod_lo;
  logic [`EX_XLEN-1:0]        result;

  ////////////////////////////////////////
  // High product, 33x33 signed
  ////////////////////////////////////////

  // SU treats a as signed and b as unsigned
  assign sign_a = (signed_mode_i != MULT_UU);
  assign sign_b = (signed_mode_i == MULT_SS);

  assign a_ext     = {sign_a & op_a_i[`EX_XLEN-1], op_a_i};
  assign b_ext     = {sign_b & op_b_i[`EX_XLEN-1], op_b_i};
  assign prod_full = a_ext * b_ext;

  // Low product is the same for every signedness
  assign prod_lo = op_a_i * op_b_i;

  // New high multiply only from idle
  assign start_high = enable_i & (operator_i == MULT_MULH) & (state_q == MULT_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE:   if (start_high) state_d = MULT_FINISH;
      // Hold the finished product until the stage moves on
      MULT_FINISH: if (res.ex_ready) state_d = MULT_IDLE;
      default:     state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (start_high) begin
      prod_q <= prod_full[2*`EX_XLEN-1:0];
    end
  end

  // Finish state wins, otherwise low or accumulate in the same cycle
  always_comb begin
    if (state_q == MULT_FINISH) begin
      result = prod_q[2*`EX_XLEN-1:`EX_XLEN];
    end else if (operator_i == MULT_MAC) begin
      result = prod_lo + op_c_i;
    end else begin
      result = prod_lo;
    end
  end

  assign res.mult_result     = result;
  assign res.mult_ready      = ~start_high;
  assign res.mult_multicycle = start_high;

  // Stage ready seen in finish always releases the held product
  a_finish_release: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == MULT_FINISH) && res.ex_ready |=> (state_q == MULT_IDLE)
  ) else $error("Multiplier stayed in finish after ex_ready");

endmodule

// File: ex_wb_reg.sv
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_wb_reg import ex_data_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ex_valid_i,
  input  logic                wb_ready_i,
  input  logic                regfile_we_i,
  input  reg_addr_t           regfile_waddr_i,
  input  logic [`EX_XLEN-1:0] lsu_rdata_i,
  output logic                regfile_we_wb_o,
  output reg_addr_t           regfile_waddr_wb_o,
  output logic [`EX_XLEN-1:0] regfile_wdata_wb_o
);

  ////////////////////////////////////////
  // Load write port register
  ////////////////////////////////////////

  // Valid already implies write-back is ready
  // An empty slot with write-back ready drains the old write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o <= 1'b0;
    end else if (ex_valid_i) begin
      regfile_we_wb_o <= regfile_we_i;
    end else if (wb_ready_i) begin
      regfile_we_wb_o <= 1'b0;
    end
  end

  // Address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid_i && regfile_we_i) begin
      regfile_waddr_wb_o <= regfile_waddr_i;
    end
  end

  // Load data arrives in the write-back cycle itself
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Write-back stall blocks ex_valid in the controller, so the slot must hold
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    !wb_ready_i |=> $stable(regfile_we_wb_o) && $stable(regfile_waddr_wb_o)
  ) else $error("EX/WB register changed during write-back stall");

endmodule

// File: ex_fwd_ctrl.sv
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_fwd_ctrl import ex_data_pkg::*; (
  input  logic                alu_en_i,
  input  logic                mult_en_i,
  input  logic                csr_access_i,
  input  logic                lsu_en_i,
  input  logic                lsu_ready_ex_i,
  input  logic                wb_ready_i,
  input  logic                branch_in_ex_i,
  input  logic                regfile_alu_we_i,
  input  reg_addr_t           regfile_alu_waddr_i,
  input  logic [`EX_XLEN-1:0] csr_rdata_i,
  ex_res_if.ctrl_mp           res,
  output logic                regfile_alu_we_fw_o,
  output reg_addr_t           regfile_alu_waddr_fw_o,
  output logic [`EX_XLEN-1:0] regfile_alu_wdata_fw_o,
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  logic any_en;
  logic units_ready;

  ////////////////////////////////////////
  // Forwarding write port
  ////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR beats multiplier beats ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = res.mult_result;
    end else begin
      regfile_alu_wdata_fw_o = res.alu_result;
    end
  end

  ////////////////////////////////////////
  // Stall logic
  ////////////////////////////////////////

  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;
  assign units_ready = res.mult_ready & lsu_ready_ex_i & wb_ready_i;

  // A branch resolves here and never needs write-back
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid goes forward only, so it ignores the branch bypass
  assign ex_valid_o = any_en & units_ready;

  assign res.ex_ready = ex_ready_o;

endmodule

// File: ex_stage.sv
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_stage import ex_op_pkg::*, ex_data_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // ALU
  input  alu_op_e             alu_operator_i,
  input  vec_mode_e           alu_vec_mode_i,
  input  logic [`EX_XLEN-1:0] alu_operand_a_i,
  input  logic [`EX_XLEN-1:0] alu_operand_b_i,
  input  logic [`EX_XLEN-1:0] alu_operand_c_i,
  input  logic                alu_en_i,
  // Multiplier
  input  mult_op_e            mult_operator_i,
  input  mult_sign_e          mult_signed_mode_i,
  input  logic [`EX_XLEN-1:0] mult_operand_a_i,
  input  logic [`EX_XLEN-1:0] mult_operand_b_i,
  input  logic [`EX_XLEN-1:0] mult_operand_c_i,
  input  logic                mult_en_i,
  output logic                mult_multicycle_o,
  // LSU, CSR and register writes
  input  logic                lsu_en_i,
  input  logic [`EX_XLEN-1:0] lsu_rdata_i,
  input  logic                csr_access_i,
  input  logic [`EX_XLEN-1:0] csr_rdata_i,
  input  logic                branch_in_ex_i,
  input  logic                regfile_alu_we_i,
  input  reg_addr_t           regfile_alu_waddr_i,
  input  logic                regfile_we_i,
  input  reg_addr_t           regfile_waddr_i,
  // Load write port
  output logic                regfile_we_wb_o,
  output reg_addr_t           regfile_waddr_wb_o,
  output logic [`EX_XLEN-1:0] regfile_wdata_wb_o,
  // Forwarding write port
  output logic                regfile_alu_we_fw_o,
  output reg_addr_t           regfile_alu_waddr_fw_o,
  output logic [`EX_XLEN-1:0] regfile_alu_wdata_fw_o,
  // Branch outcome to fetch
  output logic [`EX_XLEN-1:0] jump_target_o,
  output logic                branch_decision_o,
  // Stall control
  input  logic                lsu_ready_ex_i,
  input  logic                wb_ready_i,
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  ex_res_if res ();

  assign branch_decision_o = res.alu_cmp;
  assign jump_target_o     = alu_operand_c_i;
  assign mult_multicycle_o = res.mult_multicycle;

  ////////////////////////////////////////
  // Units
  ////////////////////////////////////////

  ex_alu u_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable_i    (alu_en_i),
    .operator_i  (alu_operator_i),
    .vec_mode_i  (alu_vec_mode_i),
    .operand_a_i (alu_operand_a_i),
    .operand_b_i (alu_operand_b_i),
    .res         (res.alu_mp)
  );

  ex_mult u_mult (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable_i      (mult_en_i),
    .operator_i    (mult_operator_i),
    .signed_mode_i (mult_signed_mode_i),
    .op_a_i        (mult_operand_a_i),
    .op_b_i        (mult_operand_b_i),
    .op_c_i        (mult_operand_c_i),
    .res           (res.mult_mp)
  );

  ////////////////////////////////////////
  // Write ports and stall control
  ////////////////////////////////////////

  ex_wb_reg u_wb_reg (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid_o),
    .wb_ready_i         (wb_ready_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o),
    .regfile_wdata_wb_o (regfile_wdata_wb_o)
  );

  ex_fwd_ctrl u_fwd_ctrl (
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .csr_rdata_i            (csr_rdata_i),
    .res                    (res.ctrl_mp),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// File: tb_ex_stage.sv
`timescale 1ns/10ps
`include "ex_cfg.svh"

module tb_ex_stage import ex_op_pkg::*, ex_data_pkg::*; ();

  localparam int XW         = `EX_XLEN;
  localparam int HW         = `EX_HALF_W;
  localparam int SEED       = 24;
  localparam int CLK_HALF   = 5;
  // Loop counts per test section
  localparam int ALU_ROUNDS = 32;
  localparam int HALF_OPS   = 96;
  localparam int BRANCH_OPS = 128;
  localparam int MULT_OPS   = 384;
  localparam int MIX_OPS    = 256;
  localparam int WB_ROUNDS  = 8;
  // About 1.5 times the expected 2000 cycles of tests with stalls and mulh
  localparam int MAX_CYCLES = 3000;

  logic clk;
  logic rst_n;
  alu_op_e alu_operator_i;
  vec_mode_e alu_vec_mode_i;
  logic [XW-1:0] alu_operand_a_i;
  logic [XW-1:0] alu_operand_b_i;
  logic [XW-1:0] alu_operand_c_i;
  logic alu_en_i;
  mult_op_e mult_operator_i;
  mult_sign_e mult_signed_mode_i;
  logic [XW-1:0] mult_operand_a_i;
  logic [XW-1:0] mult_operand_b_i;
  logic [XW-1:0] mult_operand_c_i;
  logic mult_en_i;
  logic mult_multicycle_o;
  logic lsu_en_i;
  logic [XW-1:0] lsu_rdata_i;
  logic csr_access_i;
  logic [XW-1:0] csr_rdata_i;
  logic branch_in_ex_i;
  logic regfile_alu_we_i;
  reg_addr_t regfile_alu_waddr_i;
  logic regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic regfile_we_wb_o;
  reg_addr_t regfile_waddr_wb_o;
  logic [XW-1:0] regfile_wdata_wb_o;
  logic regfile_alu_we_fw_o;
  reg_addr_t regfile_alu_waddr_fw_o;
  logic [XW-1:0] regfile_alu_wdata_fw_o;
  logic [XW-1:0] jump_target_o;
  logic branch_decision_o;
  logic lsu_ready_ex_i;
  logic wb_ready_i;
  logic ex_ready_o;
  logic ex_valid_o;

  int mismatch_cnt = 0;
  int rule_cnt     = 0;
  int cycle_cnt    = 0;

  ex_stage uut (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Signed order by flipping the sign bits before an unsigned compare
  function automatic logic compare_ref(alu_op_e op, logic [XW-1:0] a, logic [XW-1:0] b);
    logic [XW-1:0] flip;
    logic          lt_s;
    logic          lt_u;
    flip = {1'b1, {(XW-1){1'b0}}};
    lt_s = (a ^ flip) < (b ^ flip);
    lt_u = a < b;
    case (op)
      ALU_SLT, ALU_LT:   return lt_s;
      ALU_SLTU, ALU_LTU: return lt_u;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_GE:            return !lt_s;
      ALU_GEU:           return !lt_u;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [XW-1:0] alu_ref(alu_op_e op, vec_mode_e mode,
                                            logic [XW-1:0] a, logic [XW-1:0] b);
    logic [HW-1:0] hi;
    logic [HW-1:0] lo;
    logic [4:0]    sh;
    sh = b[4:0];
    // Each lane is computed on its own so nothing crosses bit HW
    hi = (op == ALU_SUB) ? a[XW-1:HW] - b[XW-1:HW] : a[XW-1:HW] + b[XW-1:HW];
    lo = (op == ALU_SUB) ? a[HW-1:0] - b[HW-1:0] : a[HW-1:0] + b[HW-1:0];
    case (op)
      ALU_ADD: return (mode == VEC_HALF) ? {hi, lo} : a + b;
      ALU_SUB: return (mode == VEC_HALF) ? {hi, lo} : a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << sh;
      ALU_SRL: return a >> sh;
      // Logical shift with the vacated top bits filled from the sign
      ALU_SRA: return (a >> sh) | ((a[XW-1] ? {XW{1'b1}} : '0) & ~({XW{1'b1}} >> sh));
      default: return {{(XW-1){1'b0}}, compare_ref(op, a, b)};
    endcase
  endfunction

  // Operands extended to 64 bits give an exact low 64-bit product
  function automatic logic [2*XW-1:0] high_product(mult_sign_e mode,
                                                   logic [XW-1:0] a, logic [XW-1:0] b);
    logic [2*XW-1:0] ax;
    logic [2*XW-1:0] bx;
    ax = {{XW{(mode != MULT_UU) & a[XW-1]}}, a};
    bx = {{XW{(mode == MULT_SS) & b[XW-1]}}, b};
    return ax * bx;
  endfunction

  logic            pend_q;
  logic [XW-1:0]   held_hi_q;
  logic            we_wb_q;
  reg_addr_t       waddr_wb_q;
  logic            start_exp;
  logic            ready_exp;
  logic            valid_exp;
  logic            cmp_exp;
  logic [XW-1:0]   mult_exp;
  logic [XW-1:0]   fw_exp;
  logic [2*XW-1:0] high_prod;

  always_comb begin
    start_exp = mult_en_i && (mult_operator_i == MULT_MULH) && !pend_q;
    ready_exp = (!start_exp && lsu_ready_ex_i && wb_ready_i) || branch_in_ex_i;
    valid_exp = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i)
                && !start_exp && lsu_ready_ex_i && wb_ready_i;
    cmp_exp   = compare_ref(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
    high_prod = high_product(mult_signed_mode_i, mult_operand_a_i, mult_operand_b_i);
    // A finished mulh is held until the stage moves on
    if (pend_q) begin
      mult_exp = held_hi_q;
    end else if (mult_operator_i == MULT_MAC) begin
      mult_exp = mult_operand_a_i * mult_operand_b_i + mult_operand_c_i;
    end else begin
      mult_exp = mult_operand_a_i * mult_operand_b_i;
    end
    if (csr_access_i) begin
      fw_exp = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_exp = mult_exp;
    end else begin
      fw_exp = alu_ref(alu_operator_i, alu_vec_mode_i, alu_operand_a_i, alu_operand_b_i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q  <= 1'b0;
      we_wb_q <= 1'b0;
    end else begin
      if (start_exp) begin
        pend_q <= 1'b1;
      end else if (pend_q && ready_exp) begin
        pend_q <= 1'b0;
      end
      if (valid_exp) begin
        we_wb_q <= regfile_we_i;
      end else if (wb_ready_i) begin
        we_wb_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_exp) begin
      held_hi_q <= high_prod[2*XW-1:XW];
    end
    if (valid_exp && regfile_we_i) begin
      waddr_wb_q <= regfile_waddr_i;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic report_mismatch(input string sig, input logic [XW-1:0] got,
                                 input logic [XW-1:0] exp);
    mismatch_cnt++;
    $display("error: %s = %h, expected %h at %0t", sig, got, exp, $time);
  endtask

  task automatic flag_violation(input string what);
    rule_cnt++;
    $display("violation: %s at %0t", what, $time);
  endtask

  a_fw_data: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_alu_wdata_fw_o == fw_exp)
    else report_mismatch("regfile_alu_wdata_fw_o", $sampled(regfile_alu_wdata_fw_o),
                         $sampled(fw_exp));
  a_fw_we: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_alu_we_fw_o == regfile_alu_we_i)
    else report_mismatch("regfile_alu_we_fw_o", 32'($sampled(regfile_alu_we_fw_o)),
                         32'($sampled(regfile_alu_we_i)));
  a_fw_waddr: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_alu_waddr_fw_o == regfile_alu_waddr_i)
    else report_mismatch("regfile_alu_waddr_fw_o", 32'($sampled(regfile_alu_waddr_fw_o)),
                         32'($sampled(regfile_alu_waddr_i)));
  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_decision_o == cmp_exp)
    else report_mismatch("branch_decision_o", 32'($sampled(branch_decision_o)),
                         32'($sampled(cmp_exp)));
  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
    jump_target_o == alu_operand_c_i)
    else report_mismatch("jump_target_o", $sampled(jump_target_o),
                         $sampled(alu_operand_c_i));
  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_ready_o == ready_exp)
    else report_mismatch("ex_ready_o", 32'($sampled(ex_ready_o)), 32'($sampled(ready_exp)));
  a_valid: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o == valid_exp)
    else report_mismatch("ex_valid_o", 32'($sampled(ex_valid_o)), 32'($sampled(valid_exp)));
  a_multicycle: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_o == start_exp)
    else report_mismatch("mult_multicycle_o", 32'($sampled(mult_multicycle_o)),
                         32'($sampled(start_exp)));
  a_wb_we: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_we_wb_o == we_wb_q)
    else report_mismatch("regfile_we_wb_o", 32'($sampled(regfile_we_wb_o)),
                         32'($sampled(we_wb_q)));
  // Address is only meaningful behind a pending write
  a_wb_waddr: assert property (@(posedge clk) disable iff (!rst_n)
    we_wb_q |-> regfile_waddr_wb_o == waddr_wb_q)
    else report_mismatch("regfile_waddr_wb_o", 32'($sampled(regfile_waddr_wb_o)),
                         32'($sampled(waddr_wb_q)));
  a_wb_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_wdata_wb_o == lsu_rdata_i)
    else report_mismatch("regfile_wdata_wb_o", $sampled(regfile_wdata_wb_o),
                         $sampled(lsu_rdata_i));
  a_mulh_once: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_o |=> !mult_multicycle_o)
    else flag_violation("mult_multicycle_o stayed high for more than one cycle");
  a_branch_ready: assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_ex_i |-> ex_ready_o)
    else flag_violation("ex_ready_o low while a branch is in EX");
  a_reset_we: assert property (@(posedge clk) !rst_n |-> !regfile_we_wb_o)
    else flag_violation("regfile_we_wb_o high during reset");

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Fresh data on every input with all enables off and readiness mostly high
  task automatic randomize_inputs();
    alu_operator_i      = alu_op_e'(4'($urandom));
    alu_vec_mode_i      = VEC_WORD;
    alu_operand_a_i     = $urandom;
    alu_operand_b_i     = $urandom;
    alu_operand_c_i     = $urandom;
    mult_operator_i     = mult_op_e'(2'($urandom_range(0, 2)));
    mult_signed_mode_i  = mult_sign_e'(2'($urandom_range(0, 2)));
    mult_operand_a_i    = $urandom;
    mult_operand_b_i    = $urandom;
    mult_operand_c_i    = $urandom;
    lsu_rdata_i         = $urandom;
    csr_rdata_i         = $urandom;
    regfile_alu_we_i    = 1'($urandom);
    regfile_alu_waddr_i = `EX_RADDR_W'($urandom);
    regfile_we_i        = 1'($urandom);
    regfile_waddr_i     = `EX_RADDR_W'($urandom);
    wb_ready_i          = ($urandom_range(0, 7) != 0);
    lsu_ready_ex_i      = ($urandom_range(0, 15) != 0);
    alu_en_i            = 1'b0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    lsu_en_i            = 1'b0;
    branch_in_ex_i      = 1'b0;
  endtask

  // Keep the op on the inputs until the stage takes it
  task automatic hold_until_ready();
    #7;
    while (!ex_ready_o) begin
      next_cycle();
      // Back-pressure may lift while the op waits
      wb_ready_i     = ($urandom_range(0, 3) != 0);
      lsu_ready_ex_i = ($urandom_range(0, 3) != 0);
      #7;
    end
    next_cycle();
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n = 1'b0;
    randomize_inputs();
    // A load with a write stands ready during reset and must not reach the EX/WB register
    lsu_en_i       = 1'b1;
    regfile_we_i   = 1'b1;
    wb_ready_i     = 1'b1;
    lsu_ready_ex_i = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // ALU word mode over every operator
    for (int r = 0; r < ALU_ROUNDS; r++) begin
      for (int op = 0; op < 16; op++) begin
        randomize_inputs();
        alu_en_i       = 1'b1;
        alu_operator_i = alu_op_e'(4'(op));
        hold_until_ready();
      end
    end

    // Half mode starts with a lane carry and a lane borrow
    randomize_inputs();
    alu_en_i        = 1'b1;
    alu_vec_mode_i  = VEC_HALF;
    alu_operator_i  = ALU_ADD;
    alu_operand_a_i = 32'h0001_FFFF;
    alu_operand_b_i = 32'h0000_0001;
    hold_until_ready();
    randomize_inputs();
    alu_en_i        = 1'b1;
    alu_vec_mode_i  = VEC_HALF;
    alu_operator_i  = ALU_SUB;
    alu_operand_a_i = 32'h0001_0000;
    alu_operand_b_i = 32'h0000_0001;
    hold_until_ready();
    for (int i = 0; i < HALF_OPS; i++) begin
      randomize_inputs();
      alu_en_i       = 1'b1;
      alu_vec_mode_i = VEC_HALF;
      alu_operator_i = $urandom_range(0, 1) ? ALU_SUB : ALU_ADD;
      hold_until_ready();
    end

    // Branch compares
    for (int i = 0; i < BRANCH_OPS; i++) begin
      randomize_inputs();
      alu_en_i       = 1'b1;
      branch_in_ex_i = 1'b1;
      alu_operator_i = alu_op_e'(4'($urandom_range(10, 15)));
      // Equal operands now and then
      if ($urandom_range(0, 3) == 0) begin
        alu_operand_b_i = alu_operand_a_i;
      end
      hold_until_ready();
    end

    // Multiplier with sign corner operands mixed in
    for (int i = 0; i < MULT_OPS; i++) begin
      randomize_inputs();
      mult_en_i = 1'b1;
      if ($urandom_range(0, 7) == 0) begin
        mult_operand_a_i = 32'h8000_0000;
      end
      if ($urandom_range(0, 7) == 0) begin
        mult_operand_b_i = 32'hFFFF_FFFF;
      end
      hold_until_ready();
    end

    // Several enables at once for the write port priority
    for (int i = 0; i < MIX_OPS; i++) begin
      randomize_inputs();
      alu_en_i     = 1'($urandom);
      mult_en_i    = 1'($urandom);
      csr_access_i = 1'($urandom);
      lsu_en_i     = 1'($urandom);
      hold_until_ready();
    end

    // EX/WB register loads, stalls and drains
    for (int i = 0; i < WB_ROUNDS; i++) begin
      randomize_inputs();
      lsu_en_i       = 1'b1;
      regfile_we_i   = 1'b1;
      wb_ready_i     = 1'b1;
      lsu_ready_ex_i = 1'b1;
      next_cycle();
      // A second load waits behind the stalled write-back
      randomize_inputs();
      lsu_en_i     = 1'b1;
      regfile_we_i = 1'b1;
      wb_ready_i   = 1'b0;
      repeat (3) next_cycle();
      // With nothing issued the slot empties
      randomize_inputs();
      wb_ready_i = 1'b1;
      next_cycle();
    end

    $display("errors: %0d value mismatches, %0d rule violations", mismatch_cnt, rule_cnt);
    if (mismatch_cnt == 0 && rule_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: stimulus still running after %0d cycles", MAX_CYCLES);
    $display("errors: %0d value mismatches, %0d rule violations", mismatch_cnt, rule_cnt);
    $display("test failed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+.
ex_op_pkg.sv
ex_data_pkg.sv
ex_res_if.sv
ex_alu.sv
ex_mult.sv
ex_wb_reg.sv
ex_fwd_ctrl.sv
ex_stage.sv
tb_ex_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_ex_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
